//--- chn_reg_pkg.sv
// DMA channel register definitions
package chn_reg_pkg;

  // ##################################################
  // Bus and address map
  // ##################################################
  localparam int unsigned REG_ADDR_W = 10;  // Decoded address bits
  localparam int unsigned DATA_W     = 32;

  localparam logic [REG_ADDR_W-1:0] CHN_BASE_ADDR = 10'h120;

  localparam logic [REG_ADDR_W-1:0] OFS_SAR        = 10'h00;
  localparam logic [REG_ADDR_W-1:0] OFS_DAR        = 10'h04;
  localparam logic [REG_ADDR_W-1:0] OFS_CTRL_A     = 10'h08;
  localparam logic [REG_ADDR_W-1:0] OFS_CTRL_B     = 10'h0C;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_MASK   = 10'h10;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_STATUS = 10'h14;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_CLEAR  = 10'h18;
  localparam logic [REG_ADDR_W-1:0] OFS_SOFT_REQ   = 10'h1C;
  localparam logic [REG_ADDR_W-1:0] OFS_EN         = 10'h20;

  // ##################################################
  // Register fields
  // ##################################################
  localparam int unsigned BLOCK_W = 12;

  // Interrupt sources, same bit order in mask, status and clear
  localparam int unsigned INT_ERR    = 0;
  localparam int unsigned INT_TFR    = 1;
  localparam int unsigned INT_HTFR   = 2;
  localparam int unsigned INT_TRGCMP = 3;
  localparam int unsigned INT_PEND   = 4;
  localparam int unsigned INT_SRC_N  = 5;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [3:0] {
    SEL_NONE, SEL_SAR, SEL_DAR, SEL_CTRL_A, SEL_CTRL_B,
    SEL_INT_MASK, SEL_INT_STATUS, SEL_INT_CLEAR, SEL_SOFT_REQ, SEL_EN
  } reg_sel_e;

endpackage

//--- chn_ahb_slave.sv
// AHB slave decode and read mux
`timescale 1ns/1ps

module chn_ahb_slave import chn_reg_pkg::*; (
  input  logic              hclk,
  input  logic              hrst_n,
  input  logic [31:0]       haddr,
  input  logic              hsel,
  input  htrans_e           htrans,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] cfg_rdata_sar,
  input  logic [DATA_W-1:0] cfg_rdata_dar,
  input  logic [DATA_W-1:0] cfg_rdata_ctrl_a,
  input  logic [DATA_W-1:0] cfg_rdata_ctrl_b,
  input  logic [DATA_W-1:0] cfg_rdata_en,
  input  logic [DATA_W-1:0] int_rdata_mask,
  input  logic [DATA_W-1:0] int_rdata_status,
  output reg_sel_e          reg_sel,
  output logic              reg_wr,
  output logic              reg_rd,
  output logic [DATA_W-1:0] hrdata
);

  logic     xfer_vld;
  reg_sel_e sel_nxt;

  assign xfer_vld = hsel && (htrans == NONSEQ || htrans == SEQ);

  // ##################################################
  // Address phase
  // ##################################################
  always_comb begin
    case (haddr[REG_ADDR_W-1:0])
      CHN_BASE_ADDR + OFS_SAR:        sel_nxt = SEL_SAR;
      CHN_BASE_ADDR + OFS_DAR:        sel_nxt = SEL_DAR;
      CHN_BASE_ADDR + OFS_CTRL_A:     sel_nxt = SEL_CTRL_A;
      CHN_BASE_ADDR + OFS_CTRL_B:     sel_nxt = SEL_CTRL_B;
      CHN_BASE_ADDR + OFS_INT_MASK:   sel_nxt = SEL_INT_MASK;
      CHN_BASE_ADDR + OFS_INT_STATUS: sel_nxt = SEL_INT_STATUS;
      CHN_BASE_ADDR + OFS_INT_CLEAR:  sel_nxt = SEL_INT_CLEAR;
      CHN_BASE_ADDR + OFS_SOFT_REQ:   sel_nxt = SEL_SOFT_REQ;
      CHN_BASE_ADDR + OFS_EN:         sel_nxt = SEL_EN;
      default:                        sel_nxt = SEL_NONE;
    endcase
  end

  // Strobes cover exactly the data phase that follows
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      reg_sel <= SEL_NONE;
      reg_wr  <= 1'b0;
      reg_rd  <= 1'b0;
    end else begin
      reg_sel <= xfer_vld ? sel_nxt : SEL_NONE;
      reg_wr  <= xfer_vld && (sel_nxt != SEL_NONE) && hwrite;
      reg_rd  <= xfer_vld && (sel_nxt != SEL_NONE) && !hwrite;
    end
  end

  // ##################################################
  // Data phase read mux
  // ##################################################
  always_comb begin
    hrdata = '0;
    if (reg_rd) begin
      case (reg_sel)
        SEL_SAR:        hrdata = cfg_rdata_sar;
        SEL_DAR:        hrdata = cfg_rdata_dar;
        SEL_CTRL_A:     hrdata = cfg_rdata_ctrl_a;
        SEL_CTRL_B:     hrdata = cfg_rdata_ctrl_b;
        SEL_INT_MASK:   hrdata = int_rdata_mask;
        SEL_INT_STATUS: hrdata = int_rdata_status;
        SEL_EN:         hrdata = cfg_rdata_en;
        default:        hrdata = '0;  // Write-only registers read zero
      endcase
    end
  end

  a_wr_rd_excl: assert property (@(posedge hclk) disable iff (!hrst_n)
    !(reg_wr && reg_rd));

endmodule

//--- chn_cfg_regs.sv
// Channel configuration registers
`timescale 1ns/1ps

module chn_cfg_regs import chn_reg_pkg::*; (
  input  logic               hclk,
  input  logic               hrst_n,
  input  reg_sel_e           reg_sel,
  input  logic               reg_wr,
  input  logic [31:0]        hwdata,
  input  logic               en_clr,
  output logic [31:0]        sar,
  output logic [31:0]        dar,
  output logic [1:0]         src_inc,
  output logic [1:0]         dst_inc,
  output logic [1:0]         src_width,
  output logic [1:0]         dst_width,
  output logic [BLOCK_W-1:0] block_size,
  output logic [2:0]         int_mode,
  output logic               endian,
  output logic               src_dtlgc,
  output logic [1:0]         trig_mode,
  output logic               int_en,
  output logic               chn_en,
  output logic               sfwtrg,
  output logic [31:0]        cfg_rdata_sar,
  output logic [31:0]        cfg_rdata_dar,
  output logic [31:0]        cfg_rdata_ctrl_a,
  output logic [31:0]        cfg_rdata_ctrl_b,
  output logic [31:0]        cfg_rdata_en
);

  logic cfg_wr;
  logic soft_req_wr;

  // Configuration is frozen while the channel runs
  assign cfg_wr      = reg_wr && !chn_en;
  assign soft_req_wr = reg_wr && (reg_sel == SEL_SOFT_REQ);

  // ##################################################
  // Addresses and control words
  // ##################################################
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sar <= '0;
      dar <= '0;
    end else begin
      if (cfg_wr && reg_sel == SEL_SAR) sar <= hwdata;
      if (cfg_wr && reg_sel == SEL_DAR) dar <= hwdata;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_mode   <= '0;
      block_size <= '0;
      src_inc    <= '0;
      dst_inc    <= '0;
      src_width  <= '0;
      dst_width  <= '0;
    end else if (cfg_wr && reg_sel == SEL_CTRL_A) begin
      int_mode   <= hwdata[26:24];
      block_size <= hwdata[23:12];
      src_inc    <= hwdata[7:6];
      dst_inc    <= hwdata[5:4];
      src_width  <= hwdata[3:2];
      dst_width  <= hwdata[1:0];
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      endian    <= 1'b0;
      src_dtlgc <= 1'b0;
      trig_mode <= '0;
      int_en    <= 1'b0;
    end else if (cfg_wr && reg_sel == SEL_CTRL_B) begin
      endian    <= hwdata[14];
      src_dtlgc <= hwdata[13];
      trig_mode <= hwdata[2:1];
      int_en    <= hwdata[0];
    end
  end

  // ##################################################
  // Enable and software request
  // ##################################################
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en <= 1'b0;
      sfwtrg <= 1'b0;
    end else begin
      if (reg_wr && reg_sel == SEL_EN)
        chn_en <= hwdata[0];  // Software write beats the engine clear
      else if (en_clr)
        chn_en <= 1'b0;
      sfwtrg <= soft_req_wr && hwdata[0];
    end
  end

  assign cfg_rdata_sar    = sar;
  assign cfg_rdata_dar    = dar;
  assign cfg_rdata_ctrl_a = {5'b0, int_mode, block_size, 4'b0,
                             src_inc, dst_inc, src_width, dst_width};
  assign cfg_rdata_ctrl_b = {17'b0, endian, src_dtlgc, 10'b0, trig_mode, int_en};
  assign cfg_rdata_en     = {31'b0, chn_en};

  a_sfwtrg_pulse: assert property (@(posedge hclk) disable iff (!hrst_n)
    sfwtrg |=> !sfwtrg);

endmodule

//--- chn_int_ctrl.sv
// Channel interrupt controller
`timescale 1ns/1ps

module chn_int_ctrl import chn_reg_pkg::*; (
  input  logic        hclk,
  input  logic        hrst_n,
  input  reg_sel_e    reg_sel,
  input  logic        reg_wr,
  input  logic [31:0] hwdata,
  input  logic        int_en,
  input  logic        ev_err,
  input  logic        ev_tfr,
  input  logic        ev_htfr,
  input  logic        ev_trgcmp,
  input  logic        ev_pend,
  output logic        irq,
  output logic        pend,
  output logic [31:0] int_rdata_mask,
  output logic [31:0] int_rdata_status
);

  logic [INT_SRC_N-1:0] ev_vec;
  logic [INT_SRC_N-1:0] mask;
  logic [INT_SRC_N-1:0] status;
  logic [INT_SRC_N-1:0] clr;

  always_comb begin
    ev_vec             = '0;
    ev_vec[INT_ERR]    = ev_err;
    ev_vec[INT_TFR]    = ev_tfr;
    ev_vec[INT_HTFR]   = ev_htfr;
    ev_vec[INT_TRGCMP] = ev_trgcmp;
    ev_vec[INT_PEND]   = ev_pend;
  end

  // ##################################################
  // Mask, clear pulses and sticky status
  // ##################################################
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask <= '0;
      clr  <= '0;
    end else begin
      if (reg_wr && reg_sel == SEL_INT_MASK)
        mask <= hwdata[INT_SRC_N-1:0];
      // Clear lasts one cycle after the data phase
      clr <= (reg_wr && reg_sel == SEL_INT_CLEAR) ? hwdata[INT_SRC_N-1:0] : '0;
    end
  end

  // A new event wins over a clear in the same cycle
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n)
      status <= '0;
    else
      status <= ev_vec | (status & ~clr);
  end

  assign irq  = |(status & mask) && int_en;
  assign pend = status[INT_PEND];

  assign int_rdata_mask   = {{(32-INT_SRC_N){1'b0}}, mask};
  assign int_rdata_status = {{(32-INT_PEND){1'b0}}, status[INT_PEND-1:0]};  // No pend here

  for (genvar i = 0; i < INT_SRC_N; i++) begin : g_ev_chk
    a_ev_sets_status: assert property (@(posedge hclk) disable iff (!hrst_n)
      ev_vec[i] |=> status[i]);
  end

endmodule

//--- chn_reg_top.sv
// DMA channel register block
`timescale 1ns/1ps

module chn_reg_top import chn_reg_pkg::*; (
  input  logic               hclk,
  input  logic               hrst_n,
  input  logic [31:0]        haddr,
  input  logic               hsel,
  input  htrans_e            htrans,
  input  logic               hwrite,
  input  logic [31:0]        hwdata,
  output logic [DATA_W-1:0]  hrdata,
  output logic [31:0]        sar,
  output logic [31:0]        dar,
  output logic [1:0]         src_inc,
  output logic [1:0]         dst_inc,
  output logic [1:0]         src_width,
  output logic [1:0]         dst_width,
  output logic [BLOCK_W-1:0] block_size,
  output logic [2:0]         int_mode,
  output logic               endian,
  output logic               src_dtlgc,
  output logic [1:0]         trig_mode,
  output logic               chn_en,
  output logic               sfwtrg,
  output logic               irq,
  output logic               pend,
  input  logic               en_clr,
  input  logic               ev_err,
  input  logic               ev_tfr,
  input  logic               ev_htfr,
  input  logic               ev_trgcmp,
  input  logic               ev_pend
);

  reg_sel_e    reg_sel;
  logic        reg_wr, reg_rd;
  logic        int_en;
  logic [31:0] cfg_rdata_sar, cfg_rdata_dar, cfg_rdata_ctrl_a;
  logic [31:0] cfg_rdata_ctrl_b, cfg_rdata_en;
  logic [31:0] int_rdata_mask, int_rdata_status;

  chn_ahb_slave u_slave (.*);

  chn_cfg_regs u_cfg (.*);

  chn_int_ctrl u_int (.*);

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic hclk,
  output logic hrst_n
);

  initial begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;  // 20 ns period
  end

  // Reset is released on a falling edge, like every other input
  initial begin
    hrst_n = 1'b0;
    repeat (8) @(posedge hclk);
    @(negedge hclk);
    hrst_n = 1'b1;
  end

endmodule

//--- tb_chn_reg.sv
// DMA channel register block testbench
`timescale 1ns/1ps

module tb_chn_reg import chn_reg_pkg::*; ();

  logic               hclk, hrst_n;
  logic [31:0]        haddr;
  logic               hsel;
  htrans_e            htrans;
  logic               hwrite;
  logic [31:0]        hwdata;
  logic [DATA_W-1:0]  hrdata;
  logic [31:0]        sar, dar;
  logic [1:0]         src_inc, dst_inc, src_width, dst_width, trig_mode;
  logic [BLOCK_W-1:0] block_size;
  logic [2:0]         int_mode;
  logic               endian, src_dtlgc, chn_en, sfwtrg, irq, pend;
  logic               en_clr, ev_err, ev_tfr, ev_htfr, ev_trgcmp, ev_pend;
  logic [31:0]        rnd;

  tb_clk_gen u_clk (.hclk(hclk), .hrst_n(hrst_n));

  chn_reg_top dut0 (.*);

  // ##################################################
  // Helpers and compare tasks
  // ##################################################
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [REG_ADDR_W-1:0] ofs);
    return {{(32-REG_ADDR_W){1'b0}}, CHN_BASE_ADDR + ofs};
  endfunction

  task automatic report_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_sel(input string what, input reg_sel_e got, input reg_sel_e exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      report_failure();
    end
  endtask

  // Address phase on one falling edge, data phase on the next
  task automatic bus_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          input logic sel, input htrans_e trans, output logic [31:0] rdata);
    @(negedge hclk);
    haddr  = addr;
    hsel   = sel;
    htrans = trans;
    hwrite = wr;
    @(negedge hclk);
    rdata  = hrdata;
    hsel   = 1'b0;
    htrans = IDLE;
    hwrite = 1'b0;
    hwdata = wdata;  // Held through the data phase edge
  endtask

  task automatic ahb_write(input logic [REG_ADDR_W-1:0] ofs, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(reg_addr(ofs), 1'b1, data, 1'b1, NONSEQ, unused);
  endtask

  task automatic ahb_read(input logic [REG_ADDR_W-1:0] ofs, output logic [31:0] data);
    bus_xfer(reg_addr(ofs), 1'b0, '0, 1'b1, NONSEQ, data);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge hclk);
  endtask

  task automatic wait_reset_release();
    int n;
    for (n = 0; n < 40 && !hrst_n; n++) @(posedge hclk);
    if (!hrst_n) begin
      $display("Reset was never released by the clock generator");
      report_failure();
    end
    @(negedge hclk);
  endtask

  task automatic wait_chn_en_low();
    int n;
    for (n = 0; n < 20 && chn_en; n++) @(negedge hclk);
    if (chn_en) begin
      $display("Channel enable did not drop after the engine clear");
      report_failure();
    end
  endtask

  task automatic pulse_event(input int idx);
    @(negedge hclk);
    ev_err    = (idx == INT_ERR);
    ev_tfr    = (idx == INT_TFR);
    ev_htfr   = (idx == INT_HTFR);
    ev_trgcmp = (idx == INT_TRGCMP);
    ev_pend   = (idx == INT_PEND);
    @(negedge hclk);
    {ev_err, ev_tfr, ev_htfr, ev_trgcmp, ev_pend} = '0;
  endtask

  task automatic count_sfwtrg(output int cnt);
    cnt = 0;
    repeat (6) begin
      @(negedge hclk);
      if (sfwtrg) cnt++;
    end
  endtask

  // ##################################################
  // Directed tests
  // ##################################################
  task automatic reset_idle_test();
    logic [REG_ADDR_W-1:0] ofs [9] = '{OFS_SAR, OFS_DAR, OFS_CTRL_A, OFS_CTRL_B, OFS_INT_MASK,
                                       OFS_INT_STATUS, OFS_INT_CLEAR, OFS_SOFT_REQ, OFS_EN};
    logic [31:0] rd;
    check_bit("chn_en after reset", chn_en, 1'b0);
    check_bit("sfwtrg after reset", sfwtrg, 1'b0);
    check_bit("irq after reset", irq, 1'b0);
    check_bit("pend after reset", pend, 1'b0);
    foreach (ofs[i]) begin
      ahb_read(ofs[i], rd);
      check_word($sformatf("reset read at offset %h", ofs[i]), rd, '0);
    end
    rnd = xorshift32(rnd);
    bus_xfer(reg_addr(OFS_SAR), 1'b1, rnd, 1'b0, NONSEQ, rd);
    check_sel("select with hsel low", dut0.u_slave.reg_sel, SEL_NONE);
    bus_xfer(reg_addr(OFS_EN), 1'b1, 32'h1, 1'b1, IDLE, rd);
    check_sel("select with htrans IDLE", dut0.u_slave.reg_sel, SEL_NONE);
    ahb_read(OFS_SAR, rd);
    check_word("SAR after ignored write", rd, '0);
    check_bit("chn_en after ignored write", chn_en, 1'b0);
  endtask

  task automatic config_test();
    logic [31:0] w_sar, w_dar, w_a, w_b, rd;
    w_sar = xorshift32(rnd);
    w_dar = xorshift32(w_sar);
    w_a   = xorshift32(w_dar);
    w_b   = xorshift32(w_a);
    rnd   = w_b;
    ahb_write(OFS_SAR, w_sar);
    ahb_write(OFS_DAR, w_dar);
    ahb_write(OFS_CTRL_A, w_a);
    ahb_write(OFS_CTRL_B, w_b);
    ahb_read(OFS_SAR, rd);
    check_word("SAR read", rd, w_sar);
    ahb_read(OFS_DAR, rd);
    check_word("DAR read", rd, w_dar);
    ahb_read(OFS_CTRL_A, rd);
    check_word("CTRL_A read", rd, w_a & 32'h07FF_F0FF);  // Group bits read zero
    ahb_read(OFS_CTRL_B, rd);
    check_word("CTRL_B read", rd, w_b & 32'h0000_6007);
    check_word("sar port", sar, w_sar);
    check_word("dar port", dar, w_dar);
    check_word("int_mode", int_mode, w_a[26:24]);
    check_word("block_size", block_size, w_a[23:12]);
    check_word("src_inc", src_inc, w_a[7:6]);
    check_word("dst_inc", dst_inc, w_a[5:4]);
    check_word("src_width", src_width, w_a[3:2]);
    check_word("dst_width", dst_width, w_a[1:0]);
    check_bit("endian", endian, w_b[14]);
    check_bit("src_dtlgc", src_dtlgc, w_b[13]);
    check_word("trig_mode", trig_mode, w_b[2:1]);
  endtask

  task automatic enable_lock_test();
    logic [31:0] old_sar, new_sar, rd;
    rnd     = xorshift32(rnd);
    old_sar = rnd;
    new_sar = ~rnd;
    ahb_write(OFS_SAR, old_sar);
    ahb_write(OFS_EN, 32'h1);
    idle_cycles(1);
    check_bit("chn_en after enable write", chn_en, 1'b1);
    ahb_write(OFS_SAR, new_sar);
    ahb_read(OFS_SAR, rd);
    check_word("SAR while locked", rd, old_sar);
    check_word("sar port while locked", sar, old_sar);
    @(negedge hclk);
    en_clr = 1'b1;
    @(negedge hclk);
    en_clr = 1'b0;
    wait_chn_en_low();
    ahb_write(OFS_SAR, new_sar);
    ahb_read(OFS_SAR, rd);
    check_word("SAR after unlock", rd, new_sar);
    check_word("sar port after unlock", sar, new_sar);
  endtask

  task automatic interrupt_test();
    logic [INT_SRC_N-1:0] exp_st, msk, clr_bits;
    logic [31:0]          rd;
    exp_st = '0;
    for (int i = 0; i < INT_SRC_N; i++) begin
      pulse_event(i);
      exp_st[i] = 1'b1;
      ahb_read(OFS_INT_STATUS, rd);
      check_word("INT_STATUS after event", rd, exp_st[INT_PEND-1:0]);
      check_bit("pend after event", pend, exp_st[INT_PEND]);
    end
    rnd = xorshift32(rnd);
    msk = rnd[INT_SRC_N-1:0];
    ahb_write(OFS_INT_MASK, msk);
    ahb_read(OFS_INT_MASK, rd);
    check_word("INT_MASK read", rd, msk);
    ahb_write(OFS_CTRL_B, 32'h1);
    idle_cycles(1);
    check_bit("irq with int_en set", irq, |(exp_st & msk));
    ahb_write(OFS_CTRL_B, 32'h0);
    idle_cycles(1);
    check_bit("irq with int_en clear", irq, 1'b0);
    clr_bits = 5'b01011;  // ERR, TFR and TRGCMP
    ahb_write(OFS_INT_CLEAR, clr_bits);
    exp_st = exp_st & ~clr_bits;
    ahb_read(OFS_INT_STATUS, rd);
    check_word("INT_STATUS after clear", rd, exp_st[INT_PEND-1:0]);
    check_bit("pend after partial clear", pend, 1'b1);
    ahb_write(OFS_INT_CLEAR, 32'h1 << INT_PEND);
    idle_cycles(2);
    check_bit("pend after its clear", pend, 1'b0);
    exp_st[INT_PEND] = 1'b0;
    ahb_write(OFS_CTRL_B, 32'h1);
    idle_cycles(1);
    check_bit("irq after clear", irq, |(exp_st & msk));
  endtask

  task automatic soft_request_test();
    int cnt;
    rnd = xorshift32(rnd);
    ahb_write(OFS_SOFT_REQ, rnd | 32'h1);
    count_sfwtrg(cnt);
    check_word("sfwtrg cycles after request", cnt, 1);
    ahb_write(OFS_SOFT_REQ, rnd & ~32'h1);
    count_sfwtrg(cnt);
    check_word("sfwtrg cycles with bit 0 clear", cnt, 0);
  endtask

  initial begin
    haddr  = '0;
    hsel   = 1'b0;
    htrans = IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    en_clr = 1'b0;
    {ev_err, ev_tfr, ev_htfr, ev_trgcmp, ev_pend} = '0;
    rnd    = 32'h17f8;
    wait_reset_release();
    reset_idle_test();
    config_test();
    enable_lock_test();
    interrupt_test();
    soft_request_test();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- tb.f
chn_reg_pkg.sv
chn_ahb_slave.sv
chn_cfg_regs.sv
chn_int_ctrl.sv
chn_reg_top.sv
tb_clk_gen.sv
tb_chn_reg.sv
